/* bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  wire             clock,
  input  wire             reset,

  // master 0 read channel.
  input  wire bus_pkg::addr_t araddr_0,
  input  wire             arvalid_0,
  output logic            arready_0,
  input  wire             rready_0,
  output bus_pkg::data_t  rdata_0,
  output bus_pkg::resp_t  rresp_0,
  output logic            rvalid_0,

  // master 1 read channel.
  input  wire bus_pkg::addr_t araddr_1,
  input  wire             arvalid_1,
  output logic            arready_1,
  input  wire             rready_1,
  output bus_pkg::data_t  rdata_1,
  output bus_pkg::resp_t  rresp_1,
  output logic            rvalid_1,

  // master 1 write channels.
  input  wire bus_pkg::addr_t awaddr_1,
  input  wire             awvalid_1,
  output logic            awready_1,
  input  wire bus_pkg::data_t wdata_1,
  input  wire bus_pkg::strb_t wstrb_1,
  input  wire             wvalid_1,
  output logic            wready_1,
  input  wire             bready_1,
  output bus_pkg::resp_t  bresp_1,
  output logic            bvalid_1,

  // clint read port.
  output bus_pkg::addr_t  clint_araddr,
  output logic            clint_arvalid,
  input  wire             clint_arready,
  output logic            clint_rready,
  input  wire bus_pkg::data_t clint_rdata,
  input  wire bus_pkg::resp_t clint_rresp,
  input  wire             clint_rvalid,

  // external memory port.
  output bus_pkg::addr_t  ext_araddr,
  output logic            ext_arvalid,
  input  wire             ext_arready,
  output logic            ext_rready,
  input  wire bus_pkg::data_t ext_rdata,
  input  wire bus_pkg::resp_t ext_rresp,
  input  wire             ext_rvalid,
  output bus_pkg::addr_t  ext_awaddr,
  output logic            ext_awvalid,
  input  wire             ext_awready,
  output bus_pkg::data_t  ext_wdata,
  output bus_pkg::strb_t  ext_wstrb,
  output logic            ext_wvalid,
  input  wire             ext_wready,
  output logic            ext_bready,
  input  wire bus_pkg::resp_t ext_bresp,
  input  wire             ext_bvalid
);

  import bus_pkg::*;

  arb_state_t state;
  logic       grant_1; // master 1 owns the current read.
  logic       ar_done;
  logic       aw_done;
  logic       w_done;

  // granted read channel, before it is steered to a target.
  addr_t      m_araddr;
  logic       m_arvalid;
  logic       m_rready;
  logic       m_ar_fire;
  logic       m_r_fire;
  logic       m_b_fire;

  function automatic logic is_timer(input addr_t addr);
    return (addr == clint_mtime_lo_addr) || (addr == clint_mtime_hi_addr);
  endfunction

  assign m_araddr  = grant_1 ? araddr_1 : araddr_0;
  assign m_arvalid = (grant_1 ? arvalid_1 : arvalid_0) && !ar_done; // one ar per grant.
  assign m_rready  = grant_1 ? rready_1 : rready_0;

  assign m_ar_fire = grant_1 ? (arvalid_1 && arready_1) : (arvalid_0 && arready_0);
  assign m_r_fire  = grant_1 ? (rvalid_1 && rready_1) : (rvalid_0 && rready_0);
  assign m_b_fire  = bvalid_1 && bready_1;

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= idle;
      grant_1 <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (arvalid_0) begin
            grant_1 <= 1'b0;
            state   <= is_timer(araddr_0) ? read_clint : read_ext;
          end else if (arvalid_1) begin
            grant_1 <= 1'b1;
            state   <= is_timer(araddr_1) ? read_clint : read_ext;
          end else if (awvalid_1) begin
            grant_1 <= 1'b1;
            state   <= is_timer(awaddr_1) ? write_err : write_ext;
          end
        end
        read_ext, read_clint: begin
          if (m_r_fire) begin
            state <= idle;
          end
        end
        write_ext, write_err: begin
          if (m_b_fire) begin
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // per-channel progress inside one grant.
  always_ff @(posedge clock) begin
    if (reset || state == idle) begin
      ar_done <= 1'b0;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      if (m_ar_fire) begin
        ar_done <= 1'b1;
      end
      if (awvalid_1 && awready_1) begin
        aw_done <= 1'b1;
      end
      if (wvalid_1 && wready_1) begin
        w_done <= 1'b1;
      end
    end
  end

  always_comb begin
    arready_0     = 1'b0;
    rdata_0       = '0;
    rresp_0       = okay;
    rvalid_0      = 1'b0;
    arready_1     = 1'b0;
    rdata_1       = '0;
    rresp_1       = okay;
    rvalid_1      = 1'b0;
    awready_1     = 1'b0;
    wready_1      = 1'b0;
    bresp_1       = okay;
    bvalid_1      = 1'b0;
    clint_araddr  = '0;
    clint_arvalid = 1'b0;
    clint_rready  = 1'b0;
    ext_araddr    = '0;
    ext_arvalid   = 1'b0;
    ext_rready    = 1'b0;
    ext_awaddr    = '0;
    ext_awvalid   = 1'b0;
    ext_wdata     = '0;
    ext_wstrb     = '0;
    ext_wvalid    = 1'b0;
    ext_bready    = 1'b0;
    case (state)
      read_ext: begin
        ext_araddr  = m_araddr;
        ext_arvalid = m_arvalid;
        ext_rready  = m_rready;
        if (grant_1) begin
          arready_1 = ext_arready && !ar_done;
          rdata_1   = ext_rdata;
          rresp_1   = ext_rresp;
          rvalid_1  = ext_rvalid;
        end else begin
          arready_0 = ext_arready && !ar_done;
          rdata_0   = ext_rdata;
          rresp_0   = ext_rresp;
          rvalid_0  = ext_rvalid;
        end
      end
      read_clint: begin
        clint_araddr  = m_araddr;
        clint_arvalid = m_arvalid;
        clint_rready  = m_rready;
        if (grant_1) begin
          arready_1 = clint_arready && !ar_done;
          rdata_1   = clint_rdata;
          rresp_1   = clint_rresp;
          rvalid_1  = clint_rvalid;
        end else begin
          arready_0 = clint_arready && !ar_done;
          rdata_0   = clint_rdata;
          rresp_0   = clint_rresp;
          rvalid_0  = clint_rvalid;
        end
      end
      write_ext: begin
        ext_awaddr  = awaddr_1;
        ext_awvalid = awvalid_1 && !aw_done;
        awready_1   = ext_awready && !aw_done;
        ext_wdata   = wdata_1;
        ext_wstrb   = wstrb_1;
        ext_wvalid  = wvalid_1 && !w_done;
        wready_1    = ext_wready && !w_done;
        ext_bready  = bready_1;
        bresp_1     = ext_bresp;
        bvalid_1    = ext_bvalid;
      end
      write_err: begin
        awready_1 = !aw_done;
        wready_1  = !w_done;
        bresp_1   = slverr;
        bvalid_1  = aw_done && w_done; // the cycle after the later of aw and w.
      end
      default: begin
      end
    endcase
  end

  property p_one_read_target;
    @(posedge clock) disable iff (reset)
      !(ext_arvalid && clint_arvalid);
  endproperty

  a_one_read_target: assert property (p_one_read_target)
    else $error("read issued to the external port and the clint at once.");

  property p_idle_quiet;
    @(posedge clock) disable iff (reset)
      (state == idle) |-> !(arready_0 || rvalid_0 || arready_1 || rvalid_1 ||
                            awready_1 || wready_1 || bvalid_1);
  endproperty

  a_idle_quiet: assert property (p_idle_quiet)
    else $error("master handshake signal active while idle.");

endmodule

`default_nettype wire

/* bus_pkg.sv */
`default_nettype none

package bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // encodings follow the AXI response field.
  typedef enum logic [1:0] {
    okay   = 2'b00,
    exokay = 2'b01,
    slverr = 2'b10,
    decerr = 2'b11
  } resp_t;

  typedef enum logic [2:0] {
    idle       = 3'd0,
    read_ext   = 3'd1,
    read_clint = 3'd2,
    write_ext  = 3'd3,
    write_err  = 3'd4
  } arb_state_t;

  // the machine timer is readable as two 32-bit words.
  localparam addr_t clint_mtime_lo_addr = 32'ha000_0048;
  localparam addr_t clint_mtime_hi_addr = 32'ha000_004c;

endpackage

`default_nettype wire

/* clint.sv */
`timescale 1ns/1ps
`default_nettype none

module clint (
  input  wire             clock,
  input  wire             reset,

  input  wire bus_pkg::addr_t araddr,
  input  wire             arvalid,
  output logic            arready,

  input  wire             rready,
  output bus_pkg::data_t  rdata,
  output bus_pkg::resp_t  rresp,
  output logic            rvalid
);

  import bus_pkg::*;

  logic [63:0] mtime;
  logic        ar_fire;
  logic        r_fire;

  assign ar_fire = arvalid && arready;
  assign r_fire  = rvalid && rready;

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1; // counts every cycle with no prescaler.
    end
  end

  // arready comes up on the first cycle out of reset and drops while a
  // response is waiting.
  always_ff @(posedge clock) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else if (ar_fire) begin
      arready <= 1'b0;
      rvalid  <= 1'b1;
    end else if (r_fire) begin
      arready <= 1'b1;
      rvalid  <= 1'b0;
    end else if (!rvalid) begin
      arready <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      if (araddr == clint_mtime_lo_addr) begin
        rdata <= mtime[31:0];
        rresp <= okay;
      end else if (araddr == clint_mtime_hi_addr) begin
        rdata <= mtime[63:32];
        rresp <= okay;
      end else begin
        rdata <= '0; // nothing else lives in the window.
        rresp <= slverr;
      end
    end
  end

  property p_rsp_hold;
    @(posedge clock) disable iff (reset)
      (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp));
  endproperty

  a_rsp_hold: assert property (p_rsp_hold)
    else $error("clint read response changed before rready.");

endmodule

`default_nettype wire

/* cpu_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_top (
  input  wire             clock,
  input  wire             reset,

  input  wire bus_pkg::addr_t araddr_0,
  input  wire             arvalid_0,
  output logic            arready_0,
  input  wire             rready_0,
  output bus_pkg::data_t  rdata_0,
  output bus_pkg::resp_t  rresp_0,
  output logic            rvalid_0,

  input  wire bus_pkg::addr_t araddr_1,
  input  wire             arvalid_1,
  output logic            arready_1,
  input  wire             rready_1,
  output bus_pkg::data_t  rdata_1,
  output bus_pkg::resp_t  rresp_1,
  output logic            rvalid_1,

  input  wire bus_pkg::addr_t awaddr_1,
  input  wire             awvalid_1,
  output logic            awready_1,
  input  wire bus_pkg::data_t wdata_1,
  input  wire bus_pkg::strb_t wstrb_1,
  input  wire             wvalid_1,
  output logic            wready_1,
  input  wire             bready_1,
  output bus_pkg::resp_t  bresp_1,
  output logic            bvalid_1,

  output bus_pkg::addr_t  ext_araddr,
  output logic            ext_arvalid,
  input  wire             ext_arready,
  output logic            ext_rready,
  input  wire bus_pkg::data_t ext_rdata,
  input  wire bus_pkg::resp_t ext_rresp,
  input  wire             ext_rvalid,
  output bus_pkg::addr_t  ext_awaddr,
  output logic            ext_awvalid,
  input  wire             ext_awready,
  output bus_pkg::data_t  ext_wdata,
  output bus_pkg::strb_t  ext_wstrb,
  output logic            ext_wvalid,
  input  wire             ext_wready,
  output logic            ext_bready,
  input  wire bus_pkg::resp_t ext_bresp,
  input  wire             ext_bvalid
);

  import bus_pkg::*;

  wire addr_t clint_araddr;
  wire        clint_arvalid;
  wire        clint_arready;
  wire        clint_rready;
  wire data_t clint_rdata;
  wire resp_t clint_rresp;
  wire        clint_rvalid;

  bus_arbiter u_arbiter (
    .clock        (clock),
    .reset        (reset),
    .araddr_0     (araddr_0),
    .arvalid_0    (arvalid_0),
    .arready_0    (arready_0),
    .rready_0     (rready_0),
    .rdata_0      (rdata_0),
    .rresp_0      (rresp_0),
    .rvalid_0     (rvalid_0),
    .araddr_1     (araddr_1),
    .arvalid_1    (arvalid_1),
    .arready_1    (arready_1),
    .rready_1     (rready_1),
    .rdata_1      (rdata_1),
    .rresp_1      (rresp_1),
    .rvalid_1     (rvalid_1),
    .awaddr_1     (awaddr_1),
    .awvalid_1    (awvalid_1),
    .awready_1    (awready_1),
    .wdata_1      (wdata_1),
    .wstrb_1      (wstrb_1),
    .wvalid_1     (wvalid_1),
    .wready_1     (wready_1),
    .bready_1     (bready_1),
    .bresp_1      (bresp_1),
    .bvalid_1     (bvalid_1),
    .clint_araddr (clint_araddr),
    .clint_arvalid(clint_arvalid),
    .clint_arready(clint_arready),
    .clint_rready (clint_rready),
    .clint_rdata  (clint_rdata),
    .clint_rresp  (clint_rresp),
    .clint_rvalid (clint_rvalid),
    .ext_araddr   (ext_araddr),
    .ext_arvalid  (ext_arvalid),
    .ext_arready  (ext_arready),
    .ext_rready   (ext_rready),
    .ext_rdata    (ext_rdata),
    .ext_rresp    (ext_rresp),
    .ext_rvalid   (ext_rvalid),
    .ext_awaddr   (ext_awaddr),
    .ext_awvalid  (ext_awvalid),
    .ext_awready  (ext_awready),
    .ext_wdata    (ext_wdata),
    .ext_wstrb    (ext_wstrb),
    .ext_wvalid   (ext_wvalid),
    .ext_wready   (ext_wready),
    .ext_bready   (ext_bready),
    .ext_bresp    (ext_bresp),
    .ext_bvalid   (ext_bvalid)
  );

  // the timer sits beside the arbiter and only sees reads.
  clint u_clint (
    .clock  (clock),
    .reset  (reset),
    .araddr (clint_araddr),
    .arvalid(clint_arvalid),
    .arready(clint_arready),
    .rready (clint_rready),
    .rdata  (clint_rdata),
    .rresp  (clint_rresp),
    .rvalid (clint_rvalid)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds and runs the interconnect testbench with Verilator.
# The exit status of the simulation is the exit status of this script.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_cpu_bus \
  -Mdir obj_dir -o tb_cpu_bus

./obj_dir/tb_cpu_bus

/* sim.f */
bus_pkg.sv
clint.sv
bus_arbiter.sv
cpu_bus_top.sv
tb_cpu_bus.sv

/* tb_cpu_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_bus;

  import bus_pkg::*;

  logic clock = 1'b0;
  logic reset = 1'b1;
  addr_t araddr_0 = '0, araddr_1 = '0, awaddr_1 = '0, ext_araddr, ext_awaddr;
  logic arvalid_0 = 1'b0, rready_0 = 1'b0, arvalid_1 = 1'b0, rready_1 = 1'b0;
  logic awvalid_1 = 1'b0, wvalid_1 = 1'b0, bready_1 = 1'b0;
  logic arready_0, rvalid_0, arready_1, rvalid_1, awready_1, wready_1, bvalid_1;
  data_t rdata_0, rdata_1, ext_wdata;
  data_t wdata_1 = '0;
  strb_t wstrb_1 = '0;
  strb_t ext_wstrb;
  resp_t rresp_0, rresp_1, bresp_1;
  logic ext_arvalid, ext_rready, ext_awvalid, ext_wvalid, ext_bready;
  logic ext_arready = 1'b0, ext_rvalid = 1'b0, ext_awready = 1'b0, ext_wready = 1'b0;
  logic ext_bvalid = 1'b0;
  data_t ext_rdata = '0;
  resp_t ext_rresp = okay, ext_bresp = okay;

  data_t ext_mem [0:255]; // contents of the external memory.
  data_t ref_mem [0:255]; // what the masters expect to read back.
  logic [63:0] mtime_model;
  logic [63:0] done_at [0:1];
  logic [31:0] seed = 32'd35;
  logic rd_pend = 1'b0, aw_got = 1'b0, w_got = 1'b0;
  addr_t rd_addr = '0, wr_addr = '0;
  data_t wr_data = '0;
  strb_t wr_strb = '0;
  logic [2:0] ar_wait = 3'd0, r_wait = 3'd0, aw_wait = 3'd0, w_wait = 3'd0, b_wait = 3'd0;

  cpu_bus_top i_dut (.*);

  always #50 clock = ~clock;

  function automatic logic [15:0] lcg16();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[30:15];
  endfunction

  function automatic logic [2:0] rand_delay();
    return 3'(lcg16() % 16'd5);
  endfunction

  function automatic logic coin();
    return (lcg16() % 16'd4) != 16'd0; // high three cycles in four.
  endfunction

  function automatic addr_t rand_ext_addr();
    return {lcg16(), 10'd0, 4'(lcg16()), 2'b00}; // small word pool so writes get read back.
  endfunction

  function automatic addr_t rand_timer_addr();
    return (lcg16() % 16'd2 == 16'd0) ? clint_mtime_lo_addr : clint_mtime_hi_addr;
  endfunction

  function automatic data_t fill_word(input int i);
    return (32'(i) * 32'h0004_0101) ^ 32'h1357_9bdf;
  endfunction

  function automatic logic is_timer_addr(input addr_t a);
    return (a == clint_mtime_lo_addr) || (a == clint_mtime_hi_addr);
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t data, input strb_t strb);
    data_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old & ~mask) | (data & mask);
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) abort_run($sformatf("[ERROR] %s = %h, expected %h", name, got, exp));
  endtask

  task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp) abort_run($sformatf("[ERROR] %s = %h, expected %h", name, got, exp));
  endtask

  task automatic check_timeout(input int waited, input string what);
    if (waited > 200) abort_run({"timeout: the ", what, " never came"});
  endtask

  always @(posedge clock) begin
    if (reset) mtime_model <= '0;
    else mtime_model <= mtime_model + 64'd1;
  end

  // the external memory answers every channel after 0 to 4 idle cycles.
  always @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 256; i++) ext_mem[8'(i)] <= fill_word(i);
      ext_arready <= 1'b0;
      ext_rvalid <= 1'b0;
      ext_awready <= 1'b0;
      ext_wready <= 1'b0;
      ext_bvalid <= 1'b0;
      rd_pend <= 1'b0;
      aw_got <= 1'b0;
      w_got <= 1'b0;
    end else begin
      if (ext_arvalid && ext_arready) begin
        ext_arready <= 1'b0;
        rd_addr <= ext_araddr;
        rd_pend <= 1'b1;
        r_wait <= rand_delay();
        ar_wait <= rand_delay();
      end else if (ext_arvalid && !rd_pend && !ext_rvalid) begin
        if (ar_wait == 3'd0) ext_arready <= 1'b1;
        else ar_wait <= ar_wait - 3'd1;
      end
      if (ext_rvalid && ext_rready) begin
        ext_rvalid <= 1'b0;
      end else if (rd_pend && !ext_rvalid) begin
        if (r_wait == 3'd0) begin
          ext_rvalid <= 1'b1;
          ext_rdata <= ext_mem[rd_addr[9:2]];
          ext_rresp <= okay;
          rd_pend <= 1'b0;
        end else r_wait <= r_wait - 3'd1;
      end
      if (ext_awvalid && ext_awready) begin
        ext_awready <= 1'b0;
        wr_addr <= ext_awaddr;
        aw_got <= 1'b1;
        aw_wait <= rand_delay();
      end else if (ext_awvalid && !aw_got) begin
        if (aw_wait == 3'd0) ext_awready <= 1'b1;
        else aw_wait <= aw_wait - 3'd1;
      end
      if (ext_wvalid && ext_wready) begin
        ext_wready <= 1'b0;
        wr_data <= ext_wdata;
        wr_strb <= ext_wstrb;
        w_got <= 1'b1;
        w_wait <= rand_delay();
      end else if (ext_wvalid && !w_got) begin
        if (w_wait == 3'd0) ext_wready <= 1'b1;
        else w_wait <= w_wait - 3'd1;
      end
      if (ext_bvalid && ext_bready) begin
        ext_bvalid <= 1'b0;
      end else if (aw_got && w_got && !ext_bvalid) begin
        if (b_wait == 3'd0) begin
          ext_mem[wr_addr[9:2]] <= merge_bytes(ext_mem[wr_addr[9:2]], wr_data, wr_strb);
          ext_bvalid <= 1'b1;
          ext_bresp <= okay;
          aw_got <= 1'b0;
          w_got <= 1'b0;
          b_wait <= rand_delay();
        end else b_wait <= b_wait - 3'd1;
      end
    end
  end

  task automatic do_read(input logic m, input addr_t addr);
    logic timer, ar_seen, rv_seen, got_r, s_ar, s_rv, s_rr;
    data_t s_data, exp_data;
    resp_t s_resp;
    int waited, ar_at;
    string sfx;
    timer = is_timer_addr(addr);
    sfx = m ? "_1" : "_0";
    ar_seen = 1'b0;
    rv_seen = 1'b0;
    got_r = 1'b0;
    waited = 0;
    ar_at = 0;
    exp_data = '0;
    if (!m) araddr_0 <= addr;
    else araddr_1 <= addr;
    if (!m) arvalid_0 <= 1'b1;
    else arvalid_1 <= 1'b1;
    while (!got_r) begin
      if (!m) rready_0 <= coin();
      else rready_1 <= coin();
      @(posedge clock);
      waited++;
      check_timeout(waited, ar_seen ? {"rvalid/rready on master", sfx} : {"ar on master", sfx});
      s_ar = !m ? (arvalid_0 && arready_0) : (arvalid_1 && arready_1);
      s_rv = !m ? rvalid_0 : rvalid_1;
      s_rr = !m ? rready_0 : rready_1;
      s_data = !m ? rdata_0 : rdata_1;
      s_resp = !m ? rresp_0 : rresp_1;
      if (s_rv) begin
        if (!ar_seen) abort_run({"read data came before the address on master", sfx});
        if (timer && !rv_seen && waited != ar_at + 1) begin
          abort_run({"timer read was late on master", sfx});
        end
        rv_seen = 1'b1;
        check_data({"rdata", sfx}, s_data, exp_data); // also catches data moving while stalled.
        check_resp({"rresp", sfx}, s_resp, okay);
        got_r = s_rr;
      end
      if (s_ar) begin
        ar_seen = 1'b1;
        ar_at = waited;
        if (timer) begin
          exp_data = (addr == clint_mtime_hi_addr) ? mtime_model[63:32] : mtime_model[31:0];
        end else begin
          exp_data = ref_mem[addr[9:2]];
        end
        if (!m) arvalid_0 <= 1'b0;
        else arvalid_1 <= 1'b0;
      end
    end
    done_at[m] = mtime_model;
    @(posedge clock);
    if (!m ? rvalid_0 : rvalid_1) abort_run({"a second read response came on master", sfx});
  endtask

  task automatic do_write(input addr_t addr, input data_t data, input strb_t strb);
    logic timer, aw_seen, w_seen, got_b;
    int waited, w_gap;
    string what;
    timer = is_timer_addr(addr);
    aw_seen = 1'b0;
    w_seen = 1'b0;
    got_b = 1'b0;
    waited = 0;
    w_gap = int'(lcg16() % 16'd3);
    awaddr_1 <= addr;
    awvalid_1 <= 1'b1;
    wdata_1 <= data;
    wstrb_1 <= strb;
    wvalid_1 <= (w_gap == 0);
    while (!got_b) begin
      bready_1 <= coin();
      @(posedge clock);
      waited++;
      if (!aw_seen) what = "aw handshake on master 1";
      else if (!w_seen) what = "w handshake on master 1";
      else what = "b handshake on master 1";
      check_timeout(waited, what);
      if (timer && (ext_awvalid || ext_wvalid)) abort_run("a timer write reached the external port");
      if (bvalid_1) begin
        if (!aw_seen || !w_seen) abort_run("write response came before address and data");
        check_resp("bresp_1", bresp_1, timer ? slverr : okay);
        got_b = bready_1;
      end
      if (awvalid_1 && awready_1) begin
        aw_seen = 1'b1;
        awvalid_1 <= 1'b0;
      end
      if (wvalid_1 && wready_1) begin
        w_seen = 1'b1;
        wvalid_1 <= 1'b0;
      end else if (!wvalid_1 && !w_seen) begin
        w_gap--;
        if (w_gap <= 0) wvalid_1 <= 1'b1;
      end
    end
    if (!timer) ref_mem[addr[9:2]] = merge_bytes(ref_mem[addr[9:2]], data, strb);
    done_at[1'b1] = mtime_model;
    @(posedge clock);
    if (bvalid_1) abort_run("a second write response came on master 1");
  endtask

  task automatic expect_master0_first();
    if (done_at[1'b0] >= done_at[1'b1]) abort_run("master 1 finished before master 0");
  endtask

  initial begin
    addr_t a0, a1;
    data_t d;
    strb_t s;
    int kind;
    for (int i = 0; i < 256; i++) ref_mem[8'(i)] = fill_word(i);
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    for (int n = 0; n < 120; n++) begin
      kind = int'(lcg16() % 16'd8);
      a0 = rand_ext_addr();
      a1 = (lcg16() % 16'd4 == 16'd0) ? rand_timer_addr() : rand_ext_addr();
      d = {lcg16(), lcg16()};
      s = 4'(lcg16());
      case (kind)
        0, 1: do_read(1'b0, a1);
        2: do_read(1'b1, a1);
        3: do_write(rand_timer_addr(), d, s);
        4: begin
          fork
            do_read(1'b0, a0);
            do_read(1'b1, a1);
          join
          expect_master0_first(); // both requests rose on the same edge.
        end
        5: begin
          fork
            do_read(1'b0, a1);
            do_write(a0, d, s);
          join
          expect_master0_first();
        end
        default: do_write(a0, d, s);
      endcase
      repeat (int'(lcg16() % 16'd4)) @(posedge clock);
    end
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire
